/* hdl/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    // ****************************************
    // Field widths
    // ****************************************
    localparam int XLen    = 32;
    localparam int RegIdxW = 5;

    typedef logic [XLen-1:0]    xlenT;
    typedef logic [RegIdxW-1:0] regIdxT;

    localparam regIdxT RegZero = '0;  // x0 is hardwired to zero

    // ****************************************
    // Major opcodes
    // ****************************************
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111
    } opcodeT;

    // Arithmetic funct3 codes
    localparam logic [2:0] F3AddSub = 3'b000;  // sub selected by funct7[5]
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

endpackage

`default_nettype wire

/* hdl/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    // ****************************************
    // Control encodings
    // ****************************************
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4
    } aluOpT;

    typedef enum logic [1:0] {
        ResAlu = 2'd0,
        ResMem = 2'd1,
        ResPc4 = 2'd2
    } resultSrcT;

    typedef enum logic [1:0] {
        ImmI = 2'd0,
        ImmS = 2'd1,
        ImmB = 2'd2,
        ImmJ = 2'd3
    } immKindT;

    typedef enum logic [1:0] {
        FwdReg = 2'd0,
        FwdWb  = 2'd1,
        FwdMem = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      jump;
        logic      branch;
        logic      aluSrc;     // Immediate as operand B
        resultSrcT resultSrc;
        aluOpT     aluOp;
    } ctrlT;

    // ****************************************
    // Pipeline registers
    // ****************************************
    typedef struct packed {
        rvIsaPkg::xlenT instr;
        rvIsaPkg::xlenT pc;
        rvIsaPkg::xlenT pcPlus4;
    } fetchDecodeT;

    typedef struct packed {
        ctrlT             ctrl;
        rvIsaPkg::xlenT   rd1;
        rvIsaPkg::xlenT   rd2;
        rvIsaPkg::xlenT   pc;
        rvIsaPkg::xlenT   pcPlus4;
        rvIsaPkg::xlenT   imm;
        rvIsaPkg::regIdxT rs1;
        rvIsaPkg::regIdxT rs2;
        rvIsaPkg::regIdxT rd;
    } decodeExecT;

    typedef struct packed {
        logic             regWrite;
        logic             memWrite;
        resultSrcT        resultSrc;
        rvIsaPkg::xlenT   aluResult;
        rvIsaPkg::xlenT   writeData;
        rvIsaPkg::xlenT   pcPlus4;
        rvIsaPkg::regIdxT rd;
    } execMemT;

    typedef struct packed {
        logic             regWrite;
        resultSrcT        resultSrc;
        rvIsaPkg::xlenT   aluResult;
        rvIsaPkg::xlenT   readData;
        rvIsaPkg::xlenT   pcPlus4;
        rvIsaPkg::regIdxT rd;
    } memWbT;

    typedef struct packed {
        fwdSelT forwardA;
        fwdSelT forwardB;
        logic   stallF;
        logic   stallD;
        logic   flushD;
        logic   flushE;
    } hazardT;

    // ****************************************
    // External ports
    // ****************************************
    typedef struct packed {
        logic           valid;
        rvIsaPkg::xlenT addr;   // Word index
        rvIsaPkg::xlenT data;
    } imemLoadT;

    typedef struct packed {
        logic           valid;
        rvIsaPkg::xlenT addr;
        rvIsaPkg::xlenT data;
    } storeT;

    typedef struct packed {
        logic             valid;
        rvIsaPkg::regIdxT rd;
        rvIsaPkg::xlenT   value;
    } retireT;

endpackage

`default_nettype wire

/* hdl/rvFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rvFetch #(
    parameter int imemWords = 1024
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rvCorePkg::imemLoadT   imemLoad,
    input  wire rvCorePkg::hazardT     hazard,
    input  wire logic                  pcSrc,
    input  wire rvIsaPkg::xlenT        pcTarget,
    output rvCorePkg::fetchDecodeT     fetchOut
);
    import rvIsaPkg::*;

    localparam int ImemAw = $clog2(imemWords);

    xlenT pc;
    xlenT pcPlus4;
    xlenT instr;
    xlenT imem [imemWords];

    assign pcPlus4 = pc + 32'd4;

    // ****************************************
    // Program counter
    // ****************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (pcSrc) begin
            pc <= pcTarget;        // Redirect wins over a stall
        end else if (!hazard.stallF) begin
            pc <= pcPlus4;
        end
    end

    // Instruction memory filled through the load port during reset
    always_ff @(posedge clk) begin
        if (imemLoad.valid) begin
            imem[imemLoad.addr[ImemAw-1:0]] <= imemLoad.data;
        end
    end

    assign instr = imem[pc[ImemAw+1:2]];

    // ****************************************
    // Fetch/decode register
    // ****************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetchOut <= '0;
        end else if (hazard.flushD) begin
            fetchOut <= '0;           // Opcode 0 bubble decodes inactive
        end else if (!hazard.stallD) begin
            fetchOut.instr   <= instr;
            fetchOut.pc      <= pc;
            fetchOut.pcPlus4 <= pcPlus4;
        end
    end

    // Program loading is only legal while the core is held in reset
    loadOnlyInReset: assert property (@(posedge clk) !(imemLoad.valid && !rst))
        else $error("imemLoad.valid high outside reset");

endmodule

`default_nettype wire

/* hdl/rvDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module rvDecode (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rvCorePkg::fetchDecodeT fetchIn,
    input  wire rvCorePkg::hazardT     hazard,
    input  wire rvCorePkg::retireT     wb,
    output rvCorePkg::decodeExecT      decodeOut,
    output rvIsaPkg::regIdxT           rs1,
    output rvIsaPkg::regIdxT           rs2
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    xlenT    instr;
    opcodeT  opcode;
    regIdxT  rd;
    ctrlT    ctrl;
    immKindT immKind;
    xlenT    imm;
    xlenT    regs [32];

    assign instr  = fetchIn.instr;
    assign opcode = opcodeT'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    function automatic aluOpT aluDecode(input logic [2:0] funct3, input logic isSub);
        case (funct3)
            F3AddSub: return isSub ? AluSub : AluAdd;
            F3Slt:    return AluSlt;
            F3Or:     return AluOr;
            F3And:    return AluAnd;
            default:  return AluAdd;
        endcase
    endfunction

    // ****************************************
    // Control decoding
    // ****************************************
    always_comb begin
        ctrl    = '0;
        immKind = ImmI;
        case (opcode)
            OpReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluDecode(instr[14:12], instr[30]);
            end
            OpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluDecode(instr[14:12], 1'b0);  // No subi
            end
            OpLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = ResMem;
            end
            OpStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immKind       = ImmS;
            end
            OpBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = AluSub;   // Zero result means equal
                immKind     = ImmB;
            end
            OpJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = ResPc4;
                immKind        = ImmJ;
            end
            default: ctrl = '0;
        endcase
    end

    // Immediate extension
    always_comb begin
        case (immKind)
            ImmI:    imm = {{20{instr[31]}}, instr[31:20]};
            ImmS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            ImmB:    imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        endcase
    end

    // ****************************************
    // Register file
    // ****************************************
    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != RegZero) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Same-cycle writeback is passed through to the read
    function automatic xlenT readReg(input regIdxT idx);
        if (idx == RegZero) begin
            return '0;
        end else if (wb.valid && wb.rd == idx) begin
            return wb.value;
        end
        return regs[idx];
    endfunction

    // Decode/execute register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decodeOut <= '0;
        end else if (hazard.flushE) begin
            decodeOut <= '0;
        end else begin
            decodeOut.ctrl    <= ctrl;
            decodeOut.rd1     <= readReg(rs1);
            decodeOut.rd2     <= readReg(rs2);
            decodeOut.pc      <= fetchIn.pc;
            decodeOut.pcPlus4 <= fetchIn.pcPlus4;
            decodeOut.imm     <= imm;
            decodeOut.rs1     <= rs1;
            decodeOut.rs2     <= rs2;
            decodeOut.rd      <= rd;
        end
    end

    x0ReadsZero: assert property (@(posedge clk) disable iff (rst)
        (rs1 == RegZero) |=> (decodeOut.rd1 == '0))
        else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

/* hdl/rvExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module rvExecute (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire rvCorePkg::decodeExecT execIn,
    input  wire rvCorePkg::hazardT    hazard,
    input  wire rvIsaPkg::xlenT       memFwd,
    input  wire rvCorePkg::retireT    wb,
    output rvCorePkg::execMemT        execOut,
    output logic                      pcSrc,
    output rvIsaPkg::xlenT            pcTarget
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    xlenT srcA;
    xlenT fwdB;
    xlenT srcB;
    xlenT aluResult;

    function automatic xlenT forwardMux(input fwdSelT sel, input xlenT regVal);
        case (sel)
            FwdMem:  return memFwd;
            FwdWb:   return wb.value;
            default: return regVal;
        endcase
    endfunction

    // ****************************************
    // Operands and ALU
    // ****************************************
    assign srcA = forwardMux(hazard.forwardA, execIn.rd1);
    assign fwdB = forwardMux(hazard.forwardB, execIn.rd2);
    assign srcB = execIn.ctrl.aluSrc ? execIn.imm : fwdB;

    always_comb begin
        case (execIn.ctrl.aluOp)
            AluSub:  aluResult = srcA - srcB;
            AluAnd:  aluResult = srcA & srcB;
            AluOr:   aluResult = srcA | srcB;
            AluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            default: aluResult = srcA + srcB;
        endcase
    end

    // Branch compare rides on the subtract
    assign pcSrc    = execIn.ctrl.jump || (execIn.ctrl.branch && aluResult == '0);
    assign pcTarget = execIn.pc + execIn.imm;

    // Execute/memory register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            execOut <= '0;
        end else begin
            execOut.regWrite  <= execIn.ctrl.regWrite;
            execOut.memWrite  <= execIn.ctrl.memWrite;
            execOut.resultSrc <= execIn.ctrl.resultSrc;
            execOut.aluResult <= aluResult;
            execOut.writeData <= fwdB;       // Store data after forwarding
            execOut.pcPlus4   <= execIn.pcPlus4;
            execOut.rd        <= execIn.rd;
        end
    end

endmodule

`default_nettype wire

/* hdl/rvHazard.sv */
`timescale 1ns/1ps
`default_nettype none

module rvHazard (
    input  wire rvIsaPkg::regIdxT      rs1,
    input  wire rvIsaPkg::regIdxT      rs2,
    input  wire rvCorePkg::decodeExecT execIn,
    input  wire rvIsaPkg::regIdxT      memRd,
    input  wire logic                  memRegWrite,
    input  wire rvIsaPkg::regIdxT      wbRd,
    input  wire logic                  wbRegWrite,
    input  wire logic                  pcSrc,
    output rvCorePkg::hazardT          hazard
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    logic loadUse;

    // Memory stage is younger, so it takes priority
    function automatic fwdSelT fwdSelect(input regIdxT src);
        if (src == RegZero) begin
            return FwdReg;
        end else if (memRegWrite && src == memRd) begin
            return FwdMem;
        end else if (wbRegWrite && src == wbRd) begin
            return FwdWb;
        end
        return FwdReg;
    endfunction

    assign loadUse = execIn.ctrl.resultSrc == ResMem && execIn.rd != RegZero
                     && (execIn.rd == rs1 || execIn.rd == rs2);

    assign hazard.forwardA = fwdSelect(execIn.rs1);
    assign hazard.forwardB = fwdSelect(execIn.rs2);
    assign hazard.stallF   = loadUse;
    assign hazard.stallD   = loadUse;
    assign hazard.flushD   = pcSrc;
    assign hazard.flushE   = pcSrc || loadUse;  // Bubble into execute

    always_comb begin
        stallPair: assert (hazard.stallF == hazard.stallD)
            else $error("fetch and decode stall disagree");
    end

endmodule

`default_nettype wire

/* hdl/rvMemWb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvMemWb #(
    parameter int dmemWords = 1024
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire rvCorePkg::execMemT memIn,
    output rvIsaPkg::xlenT         memFwd,
    output rvIsaPkg::regIdxT       memRd,
    output logic                   memRegWrite,
    output rvCorePkg::storeT       storeOut,
    output rvCorePkg::retireT      wb
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    localparam int DmemAw = $clog2(dmemWords);

    xlenT  dmem [dmemWords];
    xlenT  readData;
    xlenT  result;
    memWbT memWb;

    // ****************************************
    // Data memory cleared on reset
    // ****************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (memIn.memWrite) begin
            dmem[memIn.aluResult[DmemAw+1:2]] <= memIn.writeData;
        end
    end

    assign readData = dmem[memIn.aluResult[DmemAw+1:2]];

    // jal forwards its link value rather than the ALU sum
    assign memFwd      = (memIn.resultSrc == ResPc4) ? memIn.pcPlus4 : memIn.aluResult;
    assign memRd       = memIn.rd;
    assign memRegWrite = memIn.regWrite;

    assign storeOut.valid = memIn.memWrite;
    assign storeOut.addr  = memIn.aluResult;
    assign storeOut.data  = memIn.writeData;

    // Memory/writeback register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb.regWrite  <= memIn.regWrite;
            memWb.resultSrc <= memIn.resultSrc;
            memWb.aluResult <= memIn.aluResult;
            memWb.readData  <= readData;
            memWb.pcPlus4   <= memIn.pcPlus4;
            memWb.rd        <= memIn.rd;
        end
    end

    always_comb begin
        case (memWb.resultSrc)
            ResMem:  result = memWb.readData;
            ResPc4:  result = memWb.pcPlus4;
            default: result = memWb.aluResult;
        endcase
    end

    assign wb.valid = memWb.regWrite && memWb.rd != RegZero;
    assign wb.rd    = memWb.rd;
    assign wb.value = result;

endmodule

`default_nettype wire

/* hdl/rvCoreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop #(
    parameter int imemWords = 1024,
    parameter int dmemWords = 1024
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire rvCorePkg::imemLoadT imemLoad,
    output rvCorePkg::storeT         storeOut,
    output rvCorePkg::retireT        retireOut
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    fetchDecodeT fetchBus;
    decodeExecT  decodeBus;
    execMemT     execBus;
    hazardT      hazard;
    regIdxT      rs1;
    regIdxT      rs2;
    regIdxT      memRd;
    logic        memRegWrite;
    logic        pcSrc;
    xlenT        pcTarget;
    xlenT        memFwd;

    // ****************************************
    // Pipeline stages
    // ****************************************
    rvFetch #(.imemWords(imemWords)) fetchStage (
        .clk(clk), .rst(rst), .imemLoad(imemLoad), .hazard(hazard),
        .pcSrc(pcSrc), .pcTarget(pcTarget), .fetchOut(fetchBus)
    );

    rvDecode decodeStage (
        .clk(clk), .rst(rst), .fetchIn(fetchBus), .hazard(hazard), .wb(retireOut),
        .decodeOut(decodeBus), .rs1(rs1), .rs2(rs2)
    );

    rvExecute execStage (
        .clk(clk), .rst(rst), .execIn(decodeBus), .hazard(hazard), .memFwd(memFwd),
        .wb(retireOut), .execOut(execBus), .pcSrc(pcSrc), .pcTarget(pcTarget)
    );

    rvMemWb #(.dmemWords(dmemWords)) memWbStage (
        .clk(clk), .rst(rst), .memIn(execBus), .memFwd(memFwd), .memRd(memRd),
        .memRegWrite(memRegWrite), .storeOut(storeOut), .wb(retireOut)
    );

    // Hazard unit
    rvHazard hazardUnit (
        .rs1(rs1), .rs2(rs2), .execIn(decodeBus), .memRd(memRd),
        .memRegWrite(memRegWrite), .wbRd(retireOut.rd), .wbRegWrite(retireOut.valid),
        .pcSrc(pcSrc), .hazard(hazard)
    );

endmodule

`default_nettype wire

/* tb/rvAsm.svh */
`ifndef rvAsmSvh
`define rvAsmSvh

// ****************************************
// Instruction formats
// ****************************************
function automatic xlenT rType(input int f7, input int rs2, input int rs1, input int f3,
                               input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic xlenT iType(input int imm, input int rs1, input int f3, input int rd,
                               input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic xlenT storeWord(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// Offset in bytes from the beq itself
function automatic xlenT branchEq(input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

function automatic xlenT jumpLink(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

// ****************************************
// Mnemonics
// ****************************************
function automatic xlenT addR(input int rd, input int rs1, input int rs2);
    return rType(0, rs2, rs1, 0, rd);
endfunction

function automatic xlenT subR(input int rd, input int rs1, input int rs2);
    return rType(32, rs2, rs1, 0, rd);  // funct7 bit 5 set
endfunction

function automatic xlenT andR(input int rd, input int rs1, input int rs2);
    return rType(0, rs2, rs1, 7, rd);
endfunction

function automatic xlenT orR(input int rd, input int rs1, input int rs2);
    return rType(0, rs2, rs1, 6, rd);
endfunction

function automatic xlenT sltR(input int rd, input int rs1, input int rs2);
    return rType(0, rs2, rs1, 2, rd);
endfunction

function automatic xlenT addI(input int rd, input int rs1, input int imm);
    return iType(imm, rs1, 0, rd, 7'b0010011);
endfunction

function automatic xlenT andI(input int rd, input int rs1, input int imm);
    return iType(imm, rs1, 7, rd, 7'b0010011);
endfunction

function automatic xlenT orI(input int rd, input int rs1, input int imm);
    return iType(imm, rs1, 6, rd, 7'b0010011);
endfunction

function automatic xlenT sltI(input int rd, input int rs1, input int imm);
    return iType(imm, rs1, 2, rd, 7'b0010011);
endfunction

function automatic xlenT loadWord(input int rd, input int rs1, input int imm);
    return iType(imm, rs1, 2, rd, 7'b0000011);
endfunction

// Writes the program while the core sits in reset
task automatic loadProgram(input xlenT words[$]);
    @(posedge clk);
    #5;
    rst = 1'b1;
    foreach (words[i]) begin
        imemLoad.valid = 1'b1;
        imemLoad.addr  = i;
        imemLoad.data  = words[i];
        @(posedge clk);
        #5;
    end
    imemLoad = '0;
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
endtask

`endif

/* tb/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
    import rvIsaPkg::*;
    import rvCorePkg::*;

    logic     clk;
    logic     rst;
    imemLoadT imemLoad;
    storeT    storeOut;
    retireT   retireOut;

    xlenT prog [$];
    xlenT expAddr [$];
    xlenT expData [$];
    xlenT seenAddr [$];
    xlenT seenData [$];
    xlenT seenRd [$];
    xlenT seenValue [$];

    int errors;
    int checks;
    int cycles;
    int cycleLimit;

    `include "rvAsm.svh"

    rvCoreTop #(.imemWords(256), .dmemWords(1024)) UUT (
        .clk(clk), .rst(rst), .imemLoad(imemLoad),
        .storeOut(storeOut), .retireOut(retireOut)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Output monitors sampling away from the rising edge
    always @(negedge clk) begin
        if (!rst && storeOut.valid) begin
            seenAddr.push_back(storeOut.addr);
            seenData.push_back(storeOut.data);
        end
        if (!rst && retireOut.valid) begin
            seenRd.push_back(xlenT'(retireOut.rd));
            seenValue.push_back(retireOut.value);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: stores still missing after %0d clock cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ****************************************
    // Checking helpers
    // ****************************************
    task automatic checkEq(input string name, input xlenT actual, input xlenT expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic expectStore(input int src, input int addr, input xlenT value);
        prog.push_back(storeWord(src, 0, addr));
        expAddr.push_back(addr);
        expData.push_back(value);
    endtask

    task automatic runTest(input string name, input int retires, input int lastRd,
                           input xlenT lastValue);
        int count;
        count = expAddr.size();
        prog.push_back(jumpLink(0, 0));     // Park in a self loop
        cycleLimit += 20 * prog.size();
        seenAddr.delete();
        seenData.delete();
        seenRd.delete();
        seenValue.delete();
        loadProgram(prog);
        while (seenAddr.size() < count) begin
            @(posedge clk);
        end
        for (int i = 0; i < count; i++) begin
            checkEq($sformatf("%s storeOut.addr #%0d", name, i), seenAddr[i], expAddr[i]);
            checkEq($sformatf("%s storeOut.data #%0d", name, i), seenData[i], expData[i]);
        end
        repeat (20) @(posedge clk);
        if (seenAddr.size() != count) begin
            errors++;
            $display("%s: %0d stores arrived but only %0d were expected",
                     name, seenAddr.size(), count);
        end
        checkEq($sformatf("%s retire count", name), seenRd.size(), retires);
        if (seenRd.size() > 0) begin
            checkEq($sformatf("%s retireOut.rd", name), seenRd[$], lastRd);
            checkEq($sformatf("%s retireOut.value", name), seenValue[$], lastValue);
        end
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    // ****************************************
    // Directed tests
    // ****************************************
    task automatic arithTest();
        xlenT a;
        xlenT b;
        xlenT diff;
        xlenT both;
        xlenT either;
        xlenT masked;
        a      = 32'd25;
        b      = -32'sd7;
        diff   = b - a;
        both   = diff & b;
        either = both | a;
        masked = either & 32'h7F;
        prog.push_back(addI(1, 0, 25));
        prog.push_back(addI(2, 0, -7));
        prog.push_back(addR(3, 1, 2));
        prog.push_back(subR(4, 2, 1));
        prog.push_back(andR(5, 4, 2));
        prog.push_back(orR(6, 5, 1));
        prog.push_back(sltR(7, 2, 1));
        prog.push_back(sltR(8, 1, 2));
        prog.push_back(sltI(9, 4, -31));
        prog.push_back(andI(10, 6, 'h7F));
        prog.push_back(orI(11, 10, -256));   // 0xF00 sign extends
        expectStore(3, 'h100, a + b);
        expectStore(4, 'h104, diff);
        expectStore(5, 'h108, both);
        expectStore(6, 'h10C, either);
        expectStore(7, 'h110, 32'd1);        // -7 < 25
        expectStore(8, 'h114, 32'd0);
        expectStore(9, 'h118, 32'd1);        // -32 < -31
        expectStore(10, 'h11C, masked);
        expectStore(11, 'h120, masked | 32'hFFFFFF00);
        runTest("arith", 11, 11, masked | 32'hFFFFFF00);
    endtask

    task automatic memTest();
        xlenT val;
        val = 32'd123;
        prog.push_back(addI(1, 0, 123));
        expectStore(1, 'h200, val);
        prog.push_back(loadWord(2, 0, 'h200));
        prog.push_back(addR(3, 2, 1));          // Load-use stall
        expectStore(3, 'h204, val + val);
        prog.push_back(loadWord(4, 0, 'h100));  // Written by the arith test before the reset
        expectStore(4, 'h208, 32'd0);
        prog.push_back(loadWord(5, 0, 'h204));
        expectStore(5, 'h20C, val + val);
        runTest("load store", 5, 5, val + val);
    endtask

    task automatic branchTest();
        prog.push_back(addI(1, 0, 5));
        prog.push_back(addI(2, 0, 5));
        prog.push_back(addI(3, 0, 9));
        prog.push_back(branchEq(1, 2, 12));    // Taken
        prog.push_back(storeWord(3, 0, 'h300));
        prog.push_back(storeWord(3, 0, 'h304));
        expectStore(1, 'h308, 32'd5);
        prog.push_back(branchEq(1, 3, 12));    // Falls through
        expectStore(3, 'h30C, 32'd9);
        expectStore(2, 'h310, 32'd5);
        runTest("branch", 3, 3, 32'd9);
    endtask

    task automatic jalTest();
        xlenT link;
        prog.push_back(addI(1, 0, 1));
        link = prog.size() * 4 + 4;
        prog.push_back(jumpLink(5, 12));
        prog.push_back(storeWord(1, 0, 'h400));
        prog.push_back(storeWord(1, 0, 'h404));
        expectStore(5, 'h408, link);
        runTest("jal", 2, 5, link);
    endtask

    task automatic zeroRegTest();
        prog.push_back(addI(0, 0, 77));
        expectStore(0, 'h500, 32'd0);
        prog.push_back(addI(1, 0, 3));
        prog.push_back(addR(0, 1, 1));
        prog.push_back(addR(2, 0, 1));         // x0 must not forward
        expectStore(2, 'h504, 32'd3);
        runTest("x0", 2, 2, 32'd3);
    endtask

    task automatic randomTest();
        logic [11:0] imm;
        xlenT        total;
        total = '0;
        prog.push_back(addI(1, 0, 0));
        for (int i = 0; i < 8; i++) begin
            imm   = 12'($urandom());
            total = total + {{20{imm[11]}}, imm};
            prog.push_back(addI(1, 1, int'(imm)));
            expectStore(1, 'h600 + 4 * i, total);
        end
        runTest("random chain", 9, 1, total);
    endtask

    initial begin
        rst        = 1'b1;
        imemLoad   = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        cycleLimit = 200;
        void'($urandom(73606));
        repeat (2) @(posedge clk);
        #5;
        arithTest();
        memTest();
        branchTest();
        jalTest();
        zeroRegTest();
        randomTest();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+tb
hdl/rvIsaPkg.sv
hdl/rvCorePkg.sv
hdl/rvFetch.sv
hdl/rvDecode.sv
hdl/rvExecute.sv
hdl/rvHazard.sv
hdl/rvMemWb.sv
hdl/rvCoreTop.sv
tb/rvCoreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rvCoreTb -f all.f -o rvCoreSim

./obj_dir/rvCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
